// ==== build.f ====
verilog/mem_space_pkg.sv
verilog/store_align.sv
verilog/dmem_bank.sv
verilog/mmio_regs.sv
verilog/load_merge.sv
verilog/mem_space_top.sv
tests/mem_space_asserts.sv
tests/tb_mem_space.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_mem_space -f build.f

sim:
	verilator --binary --assert --top-module tb_mem_space -f build.f
	@out=$$(./obj_dir/Vtb_mem_space); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== tests/tb_mem_space.sv ====
`timescale 1ns/1ns

module tb_mem_space;

    // random requests in the mixed phase
    localparam int n_random = 600;
    // cycles allowed before a load result counts as lost
    localparam int rvalid_timeout = 8;

    logic                     clk;
    logic                     rst;
    mem_space_pkg::mem_req_t  req;
    mem_space_pkg::mmio_in_t  mmio_in;
    logic [31:0]              rdata;
    logic                     rvalid;
    mem_space_pkg::mmio_out_t mmio_out;

    integer seed;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // 64 words of ram as bytes
    logic [7:0]  ram_model [256];
    // bytes that hold a known value
    logic        ram_written [256];
    logic [7:0]  uart_model;
    logic        rcnt_model;

    // what the cycle after the current edge should show
    logic        pend_valid;
    logic        pend_check;
    logic [31:0] pend_data;

    mem_space_top #(
        .dmem_addr_w (14)
    ) u_mem_space_top (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .mmio_in  (mmio_in),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .mmio_out (mmio_out)
    );

    bind mem_space_top mem_space_asserts u_mem_space_asserts (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .acc    (acc),
        .rvalid (rvalid)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // bytes touched by a funct3 width
    function automatic int access_bytes(input logic [2:0] width);
        case (width)
            3'b000, 3'b100: return 1;
            3'b001, 3'b101: return 2;
            default:        return 4;
        endcase
    endfunction

    // value already moved down to lane 0
    function automatic logic [31:0] extend_value(input logic [2:0] width,
                                                 input logic [31:0] raw);
        case (width)
            3'b000:  return {{24{raw[7]}}, raw[7:0]};
            3'b001:  return {{16{raw[15]}}, raw[15:0]};
            3'b100:  return {24'd0, raw[7:0]};
            3'b101:  return {16'd0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // register map as seen by a word load
    function automatic logic [31:0] mmio_word(input logic [2:0] idx);
        case (idx)
            3'd0:    return {30'd0, mmio_in.data_out_valid, mmio_in.data_in_ready};
            3'd1:    return {24'd0, mmio_in.uart_data_out};
            3'd5:    return mmio_in.cycle_cnt;
            3'd6:    return mmio_in.instr_cnt;
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic drive_idle();
        req        = '0;
        pend_valid = 1'b0;
    endtask

    // drive one request and advance the model to match
    task automatic issue(input logic store, input logic [2:0] width,
                         input logic [31:0] addr, input logic [31:0] wdata);
        int          n;
        logic [7:0]  ba;
        logic [31:0] raw;
        logic        known;
        n         = access_bytes(width);
        req.en    = 1'b1;
        req.store = store;
        req.width = mem_space_pkg::ls_width_e'(width);
        req.addr  = addr;
        req.wdata = wdata;
        pend_valid = !store;
        pend_check = 1'b1;
        pend_data  = 32'd0;
        if (!addr[31] && store) begin
            for (int k = 0; k < n; k++) begin
                ba = addr[7:0] + 8'(k);
                ram_model[ba]   = 8'(wdata >> (8 * k));
                ram_written[ba] = 1'b1;
            end
        end else if (!addr[31]) begin
            raw   = 32'd0;
            known = 1'b1;
            for (int k = 0; k < n; k++) begin
                ba  = addr[7:0] + 8'(k);
                raw = raw | ({24'd0, ram_model[ba]} << (8 * k));
                if (!ram_written[ba]) begin
                    known = 1'b0;
                end
            end
            pend_check = known;
            pend_data  = extend_value(width, raw);
        end else if (store) begin
            // payload rides in byte lane 0, open only at offset 0
            if (addr[1:0] == 2'd0 && addr[4:2] == 3'd0) begin
                uart_model = wdata[7:0];
            end else if (addr[1:0] == 2'd0 && addr[4:2] == 3'd4) begin
                rcnt_model = wdata[0];
            end
        end else begin
            pend_data = extend_value(width, mmio_word(addr[4:2]) >> (addr[1:0] * 8));
        end
    endtask

    // one cycle on, then compare against the model
    task automatic step_and_check();
        @(negedge clk);
        check_value("rvalid", {31'd0, rvalid}, {31'd0, pend_valid});
        if (pend_valid && pend_check) begin
            check_value("rdata", rdata, pend_data);
        end
        check_value("uart_data_in", {24'd0, mmio_out.uart_data_in}, {24'd0, uart_model});
        check_value("reset_cnt", {31'd0, mmio_out.reset_cnt}, {31'd0, rcnt_model});
    endtask

    // single load, result awaited with a bound
    task automatic wait_for_rvalid();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                req = '0;
            end
            if (rvalid) begin
                seen = 1'b1;
            end else if (cycles >= rvalid_timeout) begin
                $display("no rvalid within %0d cycles after a load", rvalid_timeout);
                $display("TEST FAIL");
                $fatal(1, "load result timeout");
            end
        end
        check_value("rvalid latency", cycles, 32'd1);
        check_value("rdata", rdata, pend_data);
        pend_valid = 1'b0;
    endtask

    task automatic randomize_mmio_in();
        logic [31:0] r;
        mmio_in.instr_cnt      = $random(seed);
        mmio_in.cycle_cnt      = $random(seed);
        r                      = $random(seed);
        mmio_in.uart_data_out  = r[7:0];
        mmio_in.data_out_valid = r[8];
        mmio_in.data_in_ready  = r[9];
    endtask

    // idle 1/8, mmio 2/8, ram 5/8, always width aligned
    task automatic random_request();
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  width;
        logic [1:0]  off;
        logic        store;
        r     = $random(seed);
        r2    = $random(seed);
        store = r[3];
        case (r[7:4] % 5)
            0:       width = 3'b000;
            1:       width = 3'b001;
            2:       width = 3'b010;
            3:       width = 3'b100;
            default: width = 3'b101;
        endcase
        // no unsigned stores
        if (store) begin
            width[2] = 1'b0;
        end
        off = r[9:8];
        if (access_bytes(width) == 2) begin
            off[0] = 1'b0;
        end else if (access_bytes(width) == 4) begin
            off = 2'b00;
        end
        if (r[2:0] == 3'd0) begin
            randomize_mmio_in();
            drive_idle();
        end else if (r[2:0] <= 3'd2) begin
            // noise above bit 15, only 4:2 decode
            // ram index bits stay inside the modelled 64 words
            issue(store, width, {1'b1, r2[14:0], 8'd0, r2[17:15], r[12:10], off},
                  $random(seed));
        end else begin
            randomize_mmio_in();
            issue(store, width, {1'b0, 23'd0, r[15:10], off}, $random(seed));
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [5:0]  word_list [$];
        logic [31:0] r;
        seed        = 32'hbace_742c;
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        mmio_in     = '0;
        uart_model  = 8'd0;
        rcnt_model  = 1'b0;
        pend_valid  = 1'b0;
        pend_check  = 1'b0;
        pend_data   = 32'd0;
        ram_written = '{default: 1'b0};

        // 8 reset edges
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("rvalid in reset", {31'd0, rvalid}, 32'd0);
        end
        rst = 1'b0;

        // outputs quiet before the first request
        step_and_check();

        // word stores, then word loads back in reverse
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            word_list.push_back(r[5:0]);
            issue(1'b1, 3'b010, {24'd0, r[5:0], 2'b00}, $random(seed));
            step_and_check();
        end
        for (int i = 7; i >= 0; i--) begin
            issue(1'b0, 3'b010, {24'd0, word_list[i], 2'b00}, 32'd0);
            wait_for_rvalid();
        end

        // mixed traffic, back to back
        for (int i = 0; i < n_random; i++) begin
            random_request();
            step_and_check();
        end

        drive_idle();
        step_and_check();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tests/mem_space_asserts.sv ====
`timescale 1ns/1ns

module mem_space_asserts (
    input logic                        clk,
    input logic                        rst,
    input mem_space_pkg::mem_req_t     req,
    input mem_space_pkg::bank_access_t acc,
    input logic                        rvalid
);

    // --------------------------------------------------
    // load result timing
    // --------------------------------------------------
    // a result needs a load on the edge before
    a_rvalid_after_load: assert property (
        @(posedge clk) disable iff (rst)
        rvalid |-> $past(req.en && !req.store)
    ) else $error("rvalid with no load sampled on the previous edge");

    // every load out of reset gets its pulse
    a_load_gets_rvalid: assert property (
        @(posedge clk) disable iff (rst)
        ($past(req.en && !req.store) && !$past(rst)) |-> rvalid
    ) else $error("load sampled without rvalid one cycle later");

    // --------------------------------------------------
    // target decode
    // --------------------------------------------------
    a_one_target: assert property (
        @(posedge clk)
        !(acc.dmem_en && acc.mmio_en)
    ) else $error("ram and mmio enabled together");

    // reset holds the result path quiet
    a_quiet_in_reset: assert property (
        @(posedge clk)
        (rst && $past(rst)) |-> !rvalid
    ) else $error("rvalid high during reset");

endmodule

// ==== verilog/mem_space_top.sv ====
`timescale 1ns/1ns

module mem_space_top #(
    parameter int dmem_addr_w = 14
) (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_space_pkg::mem_req_t  req,
    input  mem_space_pkg::mmio_in_t  mmio_in,
    output logic [31:0]              rdata,
    output logic                     rvalid,
    output mem_space_pkg::mmio_out_t mmio_out
);

    // aligned access for both banks
    mem_space_pkg::bank_access_t acc;
    // registered read words
    logic [31:0] dmem_rdata;
    logic [31:0] mmio_rdata;

    // --------------------------------------------------
    // store side, combinational
    // --------------------------------------------------
    store_align u_store_align (
        .req (req),
        .acc (acc)
    );

    // --------------------------------------------------
    // banks, side by side
    // --------------------------------------------------
    // data ram
    dmem_bank #(
        .dmem_addr_w (dmem_addr_w)
    ) u_dmem_bank (
        .clk   (clk),
        .acc   (acc),
        .rdata (dmem_rdata)
    );

    // memory mapped io
    mmio_regs u_mmio_regs (
        .clk      (clk),
        .rst      (rst),
        .acc      (acc),
        .mmio_in  (mmio_in),
        .mmio_out (mmio_out),
        .rdata    (mmio_rdata)
    );

    // --------------------------------------------------
    // load side
    // --------------------------------------------------
    // result one cycle after the load edge
    load_merge u_load_merge (
        .clk        (clk),
        .rst        (rst),
        .acc        (acc),
        .store      (req.store),
        .width      (req.width),
        .dmem_rdata (dmem_rdata),
        .mmio_rdata (mmio_rdata),
        .rdata      (rdata),
        .rvalid     (rvalid)
    );

endmodule

// ==== verilog/load_merge.sv ====
`timescale 1ns/1ns

module load_merge (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_space_pkg::bank_access_t acc,
    input  logic                        store,
    input  mem_space_pkg::ls_width_e    width,
    input  logic [31:0]                 dmem_rdata,
    input  logic [31:0]                 mmio_rdata,
    output logic [31:0]                 rdata,
    output logic                        rvalid
);

    // a load is any enabled access that is not a store
    logic                     load_acc;
    // context of the load in flight
    logic                     sel_mmio_q;
    mem_space_pkg::ls_width_e width_q;
    logic [1:0]               off_q;
    // merged and shifted words
    logic [31:0]              word;
    logic [31:0]              shifted;

    assign load_acc = (acc.dmem_en | acc.mmio_en) & ~store;

    // --------------------------------------------------
    // load context
    // --------------------------------------------------
    // valid pulse lasts exactly one cycle per load
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= load_acc;
        end
    end

    // payload context, only taken on a load
    always_ff @(posedge clk) begin
        if (load_acc) begin
            sel_mmio_q <= acc.mmio_en;
            width_q    <= width;
            off_q      <= acc.addr.dmem.byte_off;
        end
    end

    // --------------------------------------------------
    // merge, shift and extend
    // --------------------------------------------------
    // bank read registers are both valid one cycle after the access
    assign word    = sel_mmio_q ? mmio_rdata : dmem_rdata;
    // addressed byte or half down to lane 0
    assign shifted = word >> {off_q, 3'b000};

    always_comb begin
        case (width_q)
            // lb, lh sign extend
            mem_space_pkg::lw_byte:   rdata = {{24{shifted[7]}}, shifted[7:0]};
            mem_space_pkg::lw_half:   rdata = {{16{shifted[15]}}, shifted[15:0]};
            mem_space_pkg::lw_word:   rdata = shifted;
            // lbu, lhu zero extend
            mem_space_pkg::lw_byte_u: rdata = {24'd0, shifted[7:0]};
            mem_space_pkg::lw_half_u: rdata = {16'd0, shifted[15:0]};
            // unused funct3 codes fall back to the full word
            default:                  rdata = shifted;
        endcase
    end

endmodule

// ==== verilog/mmio_regs.sv ====
`timescale 1ns/1ns

module mmio_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_space_pkg::bank_access_t acc,
    input  mem_space_pkg::mmio_in_t     mmio_in,
    output mem_space_pkg::mmio_out_t    mmio_out,
    output logic [31:0]                 rdata
);

    // register index from the mmio view
    logic [2:0]  reg_idx;
    // write strobe, low lane carries the payload
    logic        wr_en;
    // read word before the register
    logic [31:0] rd_word;

    assign reg_idx = acc.addr.mmio.reg_idx;
    assign wr_en   = acc.mmio_en & acc.byte_we[0];

    // --------------------------------------------------
    // write registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mmio_out.uart_data_in <= 8'd0;
            mmio_out.reset_cnt    <= 1'b0;
        end else if (wr_en) begin
            case (reg_idx)
                // uart transmit byte
                mem_space_pkg::mmio_uart_tx_stat: begin
                    mmio_out.uart_data_in <= acc.wdata[7:0];
                end
                // counter reset level
                mem_space_pkg::mmio_cnt_reset: begin
                    mmio_out.reset_cnt <= acc.wdata[0];
                end
                // other indices are read only or unmapped
                default: begin
                end
            endcase
        end
    end

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        case (reg_idx)
            // status bits
            mem_space_pkg::mmio_uart_tx_stat: begin
                rd_word = {30'd0, mmio_in.data_out_valid, mmio_in.data_in_ready};
            end
            // received byte, zero extended
            mem_space_pkg::mmio_uart_rx: begin
                rd_word = {24'd0, mmio_in.uart_data_out};
            end
            mem_space_pkg::mmio_cycle_cnt: begin
                rd_word = mmio_in.cycle_cnt;
            end
            mem_space_pkg::mmio_instr_cnt: begin
                rd_word = mmio_in.instr_cnt;
            end
            // unmapped reads as zero
            default: begin
                rd_word = 32'd0;
            end
        endcase
    end

    // sampled on any mmio access, held otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= 32'd0;
        end else if (acc.mmio_en) begin
            rdata <= rd_word;
        end
    end

endmodule

// ==== verilog/dmem_bank.sv ====
`timescale 1ns/1ns

module dmem_bank #(
    parameter int dmem_addr_w = 14
) (
    input  logic                        clk,
    input  mem_space_pkg::bank_access_t acc,
    output logic [31:0]                 rdata
);

    // number of 32-bit words
    localparam int depth = 2 ** dmem_addr_w;

    // word-wide storage, no reset
    logic [31:0] mem [depth];

    // word index, low bits of the ram view
    logic [dmem_addr_w-1:0] word_idx;

    assign word_idx = acc.addr.dmem.word_idx[dmem_addr_w-1:0];

    // --------------------------------------------------
    // write and registered read
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (acc.dmem_en) begin
            // per byte lane enables
            for (int i = 0; i < 4; i++) begin
                if (acc.byte_we[i]) begin
                    mem[word_idx][i*8 +: 8] <= acc.wdata[i*8 +: 8];
                end
            end
            // old contents come out on a write, like a block ram
            rdata <= mem[word_idx];
        end
    end

    // read data holds between accesses
    // load unit only looks at it after a ram load

endmodule

// ==== verilog/store_align.sv ====
`timescale 1ns/1ns

module store_align (
    input  mem_space_pkg::mem_req_t     req,
    output mem_space_pkg::bank_access_t acc
);

    // byte offset inside the word, same bits in both views
    logic [1:0] byte_off;
    // address bit 31 picks mmio over ram
    logic       is_mmio;
    // unshifted lane mask for the width
    logic [3:0] base_mask;
    // shift amount in bits
    logic [4:0] lane_shift;

    assign byte_off   = req.addr.dmem.byte_off;
    assign is_mmio    = req.addr.dmem.sel;
    assign lane_shift = {byte_off, 3'b000};

    // --------------------------------------------------
    // target decode
    // --------------------------------------------------
    // only place bit 31 is looked at
    assign acc.dmem_en = req.en & ~is_mmio;
    assign acc.mmio_en = req.en & is_mmio;

    // address passes through for both banks
    assign acc.addr = req.addr;

    // --------------------------------------------------
    // byte write mask
    // --------------------------------------------------
    always_comb begin
        case (req.width)
            // sb
            mem_space_pkg::lw_byte:   base_mask = 4'b0001;
            mem_space_pkg::lw_byte_u: base_mask = 4'b0001;
            // sh
            mem_space_pkg::lw_half:   base_mask = 4'b0011;
            mem_space_pkg::lw_half_u: base_mask = 4'b0011;
            // sw
            mem_space_pkg::lw_word:   base_mask = 4'b1111;
            default:                  base_mask = 4'b0000;
        endcase
    end

    // loads and idle cycles write nothing
    always_comb begin
        if (req.en && req.store) begin
            acc.byte_we = base_mask << byte_off;
        end else begin
            acc.byte_we = 4'b0000;
        end
    end

    // --------------------------------------------------
    // store data lane shift
    // --------------------------------------------------
    // shifts by 0, 1, 2 or 3 bytes
    // halves and bytes land in the lanes the mask opens
    assign acc.wdata = req.wdata << lane_shift;

endmodule

// ==== verilog/mem_space_pkg.sv ====
package mem_space_pkg;

    // --------------------------------------------------
    // funct3 access widths
    // --------------------------------------------------
    // unsigned variants only mean something for loads
    typedef enum logic [2:0] {
        lw_byte   = 3'b000,
        lw_half   = 3'b001,
        lw_word   = 3'b010,
        lw_byte_u = 3'b100,
        lw_half_u = 3'b101
    } ls_width_e;

    // --------------------------------------------------
    // address word, two decodes
    // --------------------------------------------------
    // ram view: bits 15:2 index the word
    typedef struct packed {
        logic        sel;
        logic [14:0] unused_hi;
        logic [13:0] word_idx;
        logic [1:0]  byte_off;
    } dmem_addr_t;

    // mmio view: only three register bits decoded
    typedef struct packed {
        logic        sel;
        logic [25:0] unused_hi;
        logic [2:0]  reg_idx;
        logic [1:0]  byte_off;
    } mmio_addr_t;

    typedef union packed {
        dmem_addr_t dmem;
        mmio_addr_t mmio;
    } mem_addr_u;

    // request as it leaves execute
    typedef struct packed {
        logic        en;
        logic        store;
        ls_width_e   width;
        mem_addr_u   addr;
        logic [31:0] wdata;
    } mem_req_t;

    // aligned access, shared by both banks and the load unit
    typedef struct packed {
        logic        dmem_en;
        logic        mmio_en;
        logic [3:0]  byte_we;
        mem_addr_u   addr;
        logic [31:0] wdata;
    } bank_access_t;

    // counters and uart status coming in
    typedef struct packed {
        logic [31:0] instr_cnt;
        logic [31:0] cycle_cnt;
        logic [7:0]  uart_data_out;
        logic        data_out_valid;
        logic        data_in_ready;
    } mmio_in_t;

    // uart transmit byte and counter reset going out
    typedef struct packed {
        logic [7:0] uart_data_in;
        logic       reset_cnt;
    } mmio_out_t;

    // mmio register indices
    localparam logic [2:0] mmio_uart_tx_stat = 3'd0;
    localparam logic [2:0] mmio_uart_rx      = 3'd1;
    localparam logic [2:0] mmio_cnt_reset    = 3'd4;
    localparam logic [2:0] mmio_cycle_cnt    = 3'd5;
    localparam logic [2:0] mmio_instr_cnt    = 3'd6;

endpackage
